// File: Makefile
# Verilator build and run of the execute cluster testbench.
OBJ_DIR = obj_dir

.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module exec_cluster_tb \
		--Mdir $(OBJ_DIR) -o exec_cluster_sim -f verilog.f
	./$(OBJ_DIR)/exec_cluster_sim | tee /dev/stderr | grep -x "=== PASS ===" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// File: rtl/alu_lane.sv
`include "exec_cfg.svh"

module alu_lane (
    input  logic        clk,
    input  logic        rst_n_i,
    issue_if.dst        issue,
    lane_result_if.lane res,
    output logic        credit_o
);
    import exec_pkg::*;

    localparam int PTR_W = $clog2(`LANE_DEPTH);
    localparam int CNT_W = $clog2(`LANE_DEPTH + 1);

    tag_t             tag_mem    [`LANE_DEPTH];
    opcode_t          opcode_mem [`LANE_DEPTH];
    data_t            data1_mem  [`LANE_DEPTH];
    data_t            data2_mem  [`LANE_DEPTH];
    immd_t            immd_mem   [`LANE_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             load;
    data_t            alu_result;
    flags_t           alu_flags;
    logic             res_valid_q;
    tag_t             res_tag_q;
    data_t            res_result_q;
    flags_t           res_flags_q;
    logic             credit_q;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(`LANE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // the head moves on when the result register is free or is being drained.
    assign load = (count_q != '0) && (!res_valid_q || res.grant);

    simple_alu i_simple_alu (
        .data1_i  (data1_mem[rd_ptr_q]),
        .data2_i  (data2_mem[rd_ptr_q]),
        .immd_i   (immd_mem[rd_ptr_q]),
        .opcode_i (opcode_mem[rd_ptr_q]),
        .result_o (alu_result),
        .flags_o  (alu_flags)
    );

    always_ff @(posedge clk) begin
        if (issue.valid) begin
            tag_mem[wr_ptr_q]    <= issue.tag;
            opcode_mem[wr_ptr_q] <= issue.opcode;
            data1_mem[wr_ptr_q]  <= issue.data1;
            data2_mem[wr_ptr_q]  <= issue.data2;
            immd_mem[wr_ptr_q]   <= issue.immd;
        end
        if (load) begin
            res_tag_q    <= tag_mem[rd_ptr_q];
            res_result_q <= alu_result;
            res_flags_q  <= alu_flags;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            count_q     <= '0;
            res_valid_q <= 1'b0;
            credit_q    <= 1'b0;
        end else begin
            if (issue.valid) wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (load) rd_ptr_q <= ptr_inc(rd_ptr_q);
            count_q  <= count_q + CNT_W'(issue.valid) - CNT_W'(load);
            credit_q <= load;    // one credit per entry leaving the queue.
            if (load) begin
                res_valid_q <= 1'b1;
            end else if (res.grant) begin
                res_valid_q <= 1'b0;
            end
        end
    end

    assign res.valid  = res_valid_q;
    assign res.tag    = res_tag_q;
    assign res.result = res_result_q;
    assign res.flags  = res_flags_q;
    assign credit_o   = credit_q;

endmodule

// File: rtl/exec_cfg.svh
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// datapath widths of the execute cluster.
`define SIZE_DATA       32
`define SIZE_IMMEDIATE  16
`define SIZE_OPCODE_I   6
`define EXECUTION_FLAGS 6
`define SIZE_TAG        6

`define LANE_DEPTH      4   // queue entries per lane, also the initial issue credits.
`define WB_CREDITS      2   // credits held by the merge for the writeback consumer.

// operation codes understood by each lane.
`define ADD    6'h01
`define ADDI   6'h02
`define ADDU   6'h03
`define ADDIU  6'h04
`define SUB    6'h05
`define SUBU   6'h06
`define MFHI   6'h07
`define MTHI   6'h08
`define MFLO   6'h09
`define MTLO   6'h0A
`define AND_   6'h0B
`define ANDI   6'h0C
`define OR     6'h0D
`define ORI    6'h0E
`define XOR    6'h0F
`define XORI   6'h10
`define NOR    6'h11
`define SLL    6'h12
`define SLLV   6'h13
`define SRL    6'h14
`define SRLV   6'h15
`define SRA    6'h16
`define SRAV   6'h17
`define SLT    6'h18
`define SLTI   6'h19
`define SLTU   6'h1A
`define SLTIU  6'h1B
`define LUI    6'h1C
`define NOP    6'h00

`endif

// File: rtl/exec_cluster.sv
module exec_cluster (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              wb_credit_i,

    input  logic              lane0_valid_i,
    input  exec_pkg::tag_t    lane0_tag_i,
    input  exec_pkg::opcode_t lane0_opcode_i,
    input  exec_pkg::data_t   lane0_data1_i,
    input  exec_pkg::data_t   lane0_data2_i,
    input  exec_pkg::immd_t   lane0_immd_i,
    output logic              lane0_credit_o,

    input  logic              lane1_valid_i,
    input  exec_pkg::tag_t    lane1_tag_i,
    input  exec_pkg::opcode_t lane1_opcode_i,
    input  exec_pkg::data_t   lane1_data1_i,
    input  exec_pkg::data_t   lane1_data2_i,
    input  exec_pkg::immd_t   lane1_immd_i,
    output logic              lane1_credit_o,

    output logic              wb_valid_o,
    output exec_pkg::tag_t    wb_tag_o,
    output exec_pkg::data_t   wb_result_o,
    output exec_pkg::flags_t  wb_flags_o
);

    issue_if       issue0 ();
    issue_if       issue1 ();
    lane_result_if res0 ();
    lane_result_if res1 ();

    // the scheduler only drives valid while it holds a credit for that lane.
    assign issue0.valid  = lane0_valid_i;
    assign issue0.tag    = lane0_tag_i;
    assign issue0.opcode = lane0_opcode_i;
    assign issue0.data1  = lane0_data1_i;
    assign issue0.data2  = lane0_data2_i;
    assign issue0.immd   = lane0_immd_i;

    assign issue1.valid  = lane1_valid_i;
    assign issue1.tag    = lane1_tag_i;
    assign issue1.opcode = lane1_opcode_i;
    assign issue1.data1  = lane1_data1_i;
    assign issue1.data2  = lane1_data2_i;
    assign issue1.immd   = lane1_immd_i;

    alu_lane i_alu_lane0 (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .issue    (issue0.dst),
        .res      (res0.lane),
        .credit_o (lane0_credit_o)
    );

    alu_lane i_alu_lane1 (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .issue    (issue1.dst),
        .res      (res1.lane),
        .credit_o (lane1_credit_o)
    );

    result_merge i_result_merge (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .lane0       (res0.merge),
        .lane1       (res1.merge),
        .wb_credit_i (wb_credit_i),
        .wb_valid_o  (wb_valid_o),
        .wb_tag_o    (wb_tag_o),
        .wb_result_o (wb_result_o),
        .wb_flags_o  (wb_flags_o)
    );

endmodule

// File: rtl/exec_pkg.sv
`include "exec_cfg.svh"

package exec_pkg;

    // operand and result word.
    typedef logic [`SIZE_DATA-1:0]       data_t;

    typedef logic [`SIZE_IMMEDIATE-1:0]  immd_t;   // raw immediate field.

    typedef logic [`SIZE_OPCODE_I-1:0]   opcode_t;

    // bit 4 marks a result for writeback, bit 2 is executed and bit 1 is the
    // carry or borrow exception.
    typedef logic [`EXECUTION_FLAGS-1:0] flags_t;

    typedef logic [`SIZE_TAG-1:0]        tag_t;    // destination tag.

endpackage

// File: rtl/issue_if.sv
interface issue_if;
    import exec_pkg::*;

    logic    valid;    // a beat is written into the lane queue on the edge.
    tag_t    tag;
    opcode_t opcode;
    data_t   data1;
    data_t   data2;
    immd_t   immd;

    modport src (
        output valid, tag, opcode, data1, data2, immd
    );

    modport dst (
        input  valid, tag, opcode, data1, data2, immd
    );

endinterface

// File: rtl/lane_result_if.sv
interface lane_result_if;
    import exec_pkg::*;

    // valid and the payload stay stable until grant is seen.
    logic   valid;
    tag_t   tag;
    data_t  result;
    flags_t flags;
    logic   grant;    // driven by the merge.

    modport lane (
        output valid, tag, result, flags,
        input  grant
    );

    modport merge (
        input  valid, tag, result, flags,
        output grant
    );

endinterface

// File: rtl/result_merge.sv
`include "exec_cfg.svh"

module result_merge (
    input  logic              clk,
    input  logic              rst_n_i,
    lane_result_if.merge      lane0,
    lane_result_if.merge      lane1,
    input  logic              wb_credit_i,
    output logic              wb_valid_o,
    output exec_pkg::tag_t    wb_tag_o,
    output exec_pkg::data_t   wb_result_o,
    output exec_pkg::flags_t  wb_flags_o
);

    localparam int CNT_W = $clog2(`WB_CREDITS + 1);

    logic [CNT_W-1:0] wb_cnt_q;
    logic             has_credit;
    logic             prio_q;     // set when lane 1 wins a tie.
    logic             grant0;
    logic             grant1;
    logic             any_grant;

    assign has_credit = (wb_cnt_q != '0);

    // a lane wins when the other is idle or when it holds the priority.
    assign grant0    = has_credit && lane0.valid && (!lane1.valid || !prio_q);
    assign grant1    = has_credit && lane1.valid && (!lane0.valid || prio_q);
    assign any_grant = grant0 || grant1;

    assign lane0.grant = grant0;
    assign lane1.grant = grant1;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_cnt_q <= CNT_W'(`WB_CREDITS);
            prio_q   <= 1'b0;
        end else begin
            // a returned credit and a new grant in one cycle cancel out.
            wb_cnt_q <= wb_cnt_q + CNT_W'(wb_credit_i) - CNT_W'(any_grant);

            // Priority only flips when both lanes were competing.
            if (grant0 && lane1.valid) begin
                prio_q <= 1'b1;
            end else if (grant1 && lane0.valid) begin
                prio_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= any_grant;    // high for one cycle per grant.
        end
    end

    always_ff @(posedge clk) begin
        if (grant0) begin
            wb_tag_o    <= lane0.tag;
            wb_result_o <= lane0.result;
            wb_flags_o  <= lane0.flags;
        end else if (grant1) begin
            wb_tag_o    <= lane1.tag;
            wb_result_o <= lane1.result;
            wb_flags_o  <= lane1.flags;
        end
    end

endmodule

// File: rtl/simple_alu.sv
`include "exec_cfg.svh"

module simple_alu (
    input  exec_pkg::data_t   data1_i,
    input  exec_pkg::data_t   data2_i,
    input  exec_pkg::immd_t   immd_i,
    input  exec_pkg::opcode_t opcode_i,
    output exec_pkg::data_t   result_o,
    output exec_pkg::flags_t  flags_o
);
    import exec_pkg::*;

    localparam int EXT_W = `SIZE_DATA - `SIZE_IMMEDIATE;

    data_t               immd_sext;
    data_t               immd_zext;
    logic [4:0]          shamt_immd;
    logic [4:0]          shamt_reg;
    logic [`SIZE_DATA:0] add_reg;
    logic [`SIZE_DATA:0] add_immd;
    logic [`SIZE_DATA:0] sub_reg;
    data_t               result;
    logic                executed;
    logic                exception;

    assign immd_sext = {{EXT_W{immd_i[`SIZE_IMMEDIATE-1]}}, immd_i};
    assign immd_zext = {{EXT_W{1'b0}}, immd_i};

    // only the low five bits of a shift amount count.
    assign shamt_immd = immd_i[4:0];
    assign shamt_reg  = data1_i[4:0];

    // the top bit of each sum is the carry, or the borrow for the subtract.
    assign add_reg  = {1'b0, data1_i} + {1'b0, data2_i};
    assign add_immd = {1'b0, data1_i} + {1'b0, immd_sext};
    assign sub_reg  = {1'b0, data1_i} - {1'b0, data2_i};

    always_comb begin
        result    = '0;
        executed  = 1'b1;
        exception = 1'b0;
        case (opcode_i)
            `ADD: begin
                result    = add_reg[`SIZE_DATA-1:0];
                exception = add_reg[`SIZE_DATA];
            end
            `ADDI: begin
                result    = add_immd[`SIZE_DATA-1:0];
                exception = add_immd[`SIZE_DATA];
            end
            `ADDU: begin
                result = add_reg[`SIZE_DATA-1:0];    // unsigned forms never raise.
            end
            `ADDIU: begin
                result = add_immd[`SIZE_DATA-1:0];
            end
            `SUB: begin
                result    = sub_reg[`SIZE_DATA-1:0];
                exception = sub_reg[`SIZE_DATA];
            end
            `SUBU: begin
                result = sub_reg[`SIZE_DATA-1:0];
            end
            // HI and LO are not modelled, so the moves just forward operand 1.
            `MFHI, `MTHI, `MFLO, `MTLO: begin
                result = data1_i;
            end
            `AND_: begin
                result = data1_i & data2_i;
            end
            `ANDI: begin
                result = data1_i & immd_zext;
            end
            `OR: begin
                result = data1_i | data2_i;
            end
            `ORI: begin
                result = data1_i | immd_zext;
            end
            `XOR: begin
                result = data1_i ^ data2_i;
            end
            `XORI: begin
                result = data1_i ^ immd_zext;
            end
            `NOR: begin
                result = ~(data1_i | data2_i);
            end
            `SLL: begin
                result = data1_i << shamt_immd;
            end
            `SLLV: begin
                result = data2_i << shamt_reg;    // variable forms shift operand 2.
            end
            `SRL: begin
                result = data1_i >> shamt_immd;
            end
            `SRLV: begin
                result = data2_i >> shamt_reg;
            end
            `SRA: begin
                result = data_t'($signed(data1_i) >>> shamt_immd);
            end
            `SRAV: begin
                result = data_t'($signed(data2_i) >>> shamt_reg);
            end
            `SLT: begin
                result = data_t'($signed(data1_i) < $signed(data2_i));
            end
            `SLTI: begin
                result = data_t'($signed(data1_i) < $signed(immd_sext));
            end
            `SLTU: begin
                result = data_t'(data1_i < data2_i);
            end
            `SLTIU: begin
                result = data_t'(data1_i < immd_zext);
            end
            `LUI: begin
                result = {immd_i, {EXT_W{1'b0}}};
            end
            default: begin
                executed = 1'b0;    // NOP and unknown codes leave a zero result.
            end
        endcase
    end

    assign result_o = result;
    assign flags_o  = {1'b0, 1'b1, 1'b0, executed, exception, 1'b0};

endmodule

// File: verif/exec_vectors.svh
// a row is lane, tag, opcode, data1, data2, immediate, expected result and expected flags.
// the row index is the tag minus one.
add_vec(1'b0, 6'd1,  `ADD,   32'h00000005, 32'h00000007, 16'h0000, 32'h0000000c, F_EX);
add_vec(1'b1, 6'd2,  `ADD,   32'hffffffff, 32'h00000002, 16'h0000, 32'h00000001, F_EXC);
add_vec(1'b0, 6'd3,  `ADDI,  32'h00000010, 32'h00000000, 16'hfffe, 32'h0000000e, F_EXC);
add_vec(1'b1, 6'd4,  `ADDU,  32'h80000000, 32'h80000000, 16'h0000, 32'h00000000, F_EX);
add_vec(1'b0, 6'd5,  `ADDIU, 32'h00000100, 32'h00000000, 16'h8000, 32'hffff8100, F_EX);
add_vec(1'b1, 6'd6,  `SUB,   32'h00000009, 32'h00000003, 16'h0000, 32'h00000006, F_EX);
add_vec(1'b0, 6'd7,  `SUB,   32'h00000003, 32'h00000009, 16'h0000, 32'hfffffffa, F_EXC);
add_vec(1'b1, 6'd8,  `SUBU,  32'h00000000, 32'h00000001, 16'h0000, 32'hffffffff, F_EX);

// logic ops, where the immediate forms zero-extend.
add_vec(1'b0, 6'd9,  `AND_,  32'hf0f01234, 32'h0ff0ff00, 16'h0000, 32'h00f01200, F_EX);
add_vec(1'b1, 6'd10, `ANDI,  32'hffffabcd, 32'h00000000, 16'hf00f, 32'h0000a00d, F_EX);
add_vec(1'b0, 6'd11, `OR,    32'h12000034, 32'h00456700, 16'h0000, 32'h12456734, F_EX);
add_vec(1'b1, 6'd12, `ORI,   32'h80000000, 32'h00000000, 16'h8001, 32'h80008001, F_EX);
add_vec(1'b0, 6'd13, `XOR,   32'hffff0000, 32'h0f0f0f0f, 16'h0000, 32'hf0f00f0f, F_EX);
add_vec(1'b1, 6'd14, `XORI,  32'h12345678, 32'h00000000, 16'hffff, 32'h1234a987, F_EX);
add_vec(1'b0, 6'd15, `NOR,   32'h000000ff, 32'hff000000, 16'h0000, 32'h00ffff00, F_EX);

// shifts take the low five bits of the amount.
add_vec(1'b1, 6'd16, `SLL,   32'h00000003, 32'h00000000, 16'h0024, 32'h00000030, F_EX);
add_vec(1'b0, 6'd17, `SLLV,  32'h00000021, 32'h80000001, 16'h0000, 32'h00000002, F_EX);
add_vec(1'b1, 6'd18, `SRL,   32'h80000000, 32'h00000000, 16'h001f, 32'h00000001, F_EX);
add_vec(1'b0, 6'd19, `SRLV,  32'h00000004, 32'hf0000000, 16'h0000, 32'h0f000000, F_EX);
add_vec(1'b1, 6'd20, `SRA,   32'h80000000, 32'h00000000, 16'h0004, 32'hf8000000, F_EX);
add_vec(1'b0, 6'd21, `SRAV,  32'h00000008, 32'h87654321, 16'h0000, 32'hff876543, F_EX);

// signed and unsigned compares on the same bit patterns.
add_vec(1'b1, 6'd22, `SLT,   32'hfffffffe, 32'h00000001, 16'h0000, 32'h00000001, F_EX);
add_vec(1'b0, 6'd23, `SLTI,  32'h00000001, 32'h00000000, 16'hffff, 32'h00000000, F_EX);
add_vec(1'b1, 6'd24, `SLTU,  32'hfffffffe, 32'h00000001, 16'h0000, 32'h00000000, F_EX);
add_vec(1'b0, 6'd25, `SLTIU, 32'h00000005, 32'h00000000, 16'hffff, 32'h00000001, F_EX);

add_vec(1'b1, 6'd26, `LUI,   32'h00000000, 32'h00000000, 16'habcd, 32'habcd0000, F_EX);
add_vec(1'b0, 6'd27, `MFHI,  32'hdeadbeef, 32'h00000000, 16'h0000, 32'hdeadbeef, F_EX);
add_vec(1'b1, 6'd28, `MTLO,  32'h01234567, 32'h00000000, 16'h0000, 32'h01234567, F_EX);
add_vec(1'b0, 6'd29, `NOP,   32'hffffffff, 32'hffffffff, 16'hffff, 32'h00000000, F_NOP);

// File: verif/exec_cluster_tb.sv
`include "exec_cfg.svh"

module exec_cluster_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import exec_pkg::*;

    localparam int TIMEOUT = 200;      // cycles any single wait may take.
    localparam flags_t F_EX  = 6'h14;  // writeback and executed bits.
    localparam flags_t F_EXC = 6'h16;
    localparam flags_t F_NOP = 6'h10;

    typedef struct packed {
        logic    lane;
        tag_t    tag;
        opcode_t opcode;
        data_t   data1;
        data_t   data2;
        immd_t   immd;
        data_t   result;
        flags_t  flags;
    } vec_t;

    logic    clk;
    logic    rst_n_i;
    logic    wb_credit_i;
    logic    lane_valid [2];
    tag_t    lane_tag [2];
    opcode_t lane_opcode [2];
    data_t   lane_data1 [2];
    data_t   lane_data2 [2];
    immd_t   lane_immd [2];
    logic    lane_credit [2];
    logic    wb_valid;
    tag_t    wb_tag;
    data_t   wb_result;
    flags_t  wb_flags;

    vec_t        vecs [$];
    int          exp_row [2][128];  // table rows in issue order, per lane.
    int          wr_idx [2];
    int          rd_idx [2];
    int          issued [2];
    int          pulses [2];        // issue credits seen on lane_credit.
    int          wb_recv, wb_returned;
    int          mon_errors, drv_errors, errs_before;
    int          test_num, passed, failed;
    logic        wb_hold;
    logic [15:0] lfsr_q;

    exec_cluster i_exec_cluster (
        .clk (clk), .rst_n_i (rst_n_i), .wb_credit_i (wb_credit_i),
        .lane0_valid_i (lane_valid[0]), .lane0_tag_i (lane_tag[0]),
        .lane0_opcode_i (lane_opcode[0]), .lane0_data1_i (lane_data1[0]),
        .lane0_data2_i (lane_data2[0]), .lane0_immd_i (lane_immd[0]),
        .lane0_credit_o (lane_credit[0]),
        .lane1_valid_i (lane_valid[1]), .lane1_tag_i (lane_tag[1]),
        .lane1_opcode_i (lane_opcode[1]), .lane1_data1_i (lane_data1[1]),
        .lane1_data2_i (lane_data2[1]), .lane1_immd_i (lane_immd[1]),
        .lane1_credit_o (lane_credit[1]),
        .wb_valid_o (wb_valid), .wb_tag_o (wb_tag),
        .wb_result_o (wb_result), .wb_flags_o (wb_flags)
    );

    always #20 clk = ~clk;

    task automatic add_vec(input logic ln, input tag_t tg, input opcode_t op, input data_t d1,
                           input data_t d2, input immd_t im, input data_t res, input flags_t fl);
        vec_t v;
        v = '{ln, tg, op, d1, d2, im, res, fl};
        vecs.push_back(v);
    endtask

    task automatic load_table();
        `include "exec_vectors.svh"
    endtask

    // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11.
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic int credits_left(input int lane);
        return `LANE_DEPTH + pulses[lane] - issued[lane];
    endfunction

    function automatic vec_t head_of(input int lane);
        return vecs[exp_row[lane][rd_idx[lane]]];
    endfunction

    task automatic check_result(input data_t got, input data_t exp, input string name);
        if (got !== exp) begin
            $display("error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            mon_errors++;
        end
    endtask

    task automatic check_flags(input flags_t got, input flags_t exp, input string name);
        if (got !== exp) begin
            $display("error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
            mon_errors++;
        end
    endtask

    task automatic check_tag(input tag_t got, input tag_t exp, input string name);
        if (got !== exp) begin
            $display("error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
            mon_errors++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("failure at %0t ns: %s", $time, msg);
        drv_errors++;
    endtask

    // a writeback belongs to the lane whose oldest entry carries its tag.
    task automatic match_writeback();
        int   lane;
        vec_t head0;
        vec_t v;
        lane = (rd_idx[0] != wr_idx[0]) ? 0 : 1;
        if (rd_idx[0] != wr_idx[0] && rd_idx[1] != wr_idx[1]) begin
            head0 = head_of(0);
            if (head0.tag != wb_tag) lane = 1;
        end
        if (rd_idx[lane] == wr_idx[lane]) begin
            $display("failure at %0t ns: writeback of tag %0d with nothing outstanding",
                     $time, wb_tag);
            mon_errors++;
        end else begin
            v = head_of(lane);
            rd_idx[lane]++;
            check_tag(wb_tag, v.tag, "wb_tag_o");
            check_result(wb_result, v.result, "wb_result_o");
            check_flags(wb_flags, v.flags, "wb_flags_o");
        end
    endtask

    // outputs are read on the rising edge, before the DUT updates them.
    always @(posedge clk) begin
        if (rst_n_i) begin
            if (lane_credit[0]) pulses[0]++;
            if (lane_credit[1]) pulses[1]++;
            if (wb_valid) begin
                wb_recv++;
                match_writeback();
            end
        end
    end

    // one falling edge, with a random writeback credit returned for each result owed.
    task automatic tick();
        @(negedge clk);
        lane_valid[0] = 1'b0;
        lane_valid[1] = 1'b0;
        wb_credit_i = 1'b0;
        if (!wb_hold && wb_recv != wb_returned) begin
            if (lfsr_bit()) begin
                wb_credit_i = 1'b1;
                wb_returned++;
            end
        end
    endtask

    task automatic issue_rows(input int row0, input int row1);
        int rows [2];
        int waited;
        rows[0] = row0;
        rows[1] = row1;
        waited = 0;
        while ((row0 >= 0 && credits_left(0) == 0) ||
               (row1 >= 0 && credits_left(1) == 0)) begin
            if (waited == TIMEOUT) begin
                report_failure("no issue credit came back");
                return;
            end
            waited++;
            tick();
        end
        for (int l = 0; l < 2; l++) begin
            if (rows[l] >= 0) begin
                lane_valid[l]  = 1'b1;
                lane_tag[l]    = vecs[rows[l]].tag;
                lane_opcode[l] = vecs[rows[l]].opcode;
                lane_data1[l]  = vecs[rows[l]].data1;
                lane_data2[l]  = vecs[rows[l]].data2;
                lane_immd[l]   = vecs[rows[l]].immd;
                exp_row[l][wr_idx[l]] = rows[l];
                wr_idx[l]++;
                issued[l]++;
            end
        end
        tick();
    endtask

    task automatic issue_own(input int row);
        if (vecs[row].lane) issue_rows(-1, row);
        else issue_rows(row, -1);
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (rd_idx[0] != wr_idx[0] || rd_idx[1] != wr_idx[1] || wb_recv != wb_returned) begin
            if (waited == TIMEOUT) begin
                report_failure("results still outstanding at the timeout");
                return;
            end
            waited++;
            tick();
        end
    endtask

    task automatic run_table(input int first, input int last);
        for (int r = first; r <= last; r++) begin
            if (lfsr_bit()) tick();    // random idle gap.
            issue_own(r);
        end
        wait_drained();
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = mon_errors + drv_errors;
        test_num++;
        if (errs == errs_before) begin
            passed++;
            $display("test %0d %s: ok", test_num, name);
        end else begin
            failed++;
            $display("test %0d %s: failed, %0d errors", test_num, name, errs - errs_before);
        end
        errs_before = errs;
    endtask

    initial begin
        int base;
        int pulse_base;
        int held;
        clk = 1'b0;
        rst_n_i = 1'b0;
        wb_credit_i = 1'b0;
        wb_hold = 1'b0;
        lfsr_q = 16'd2914;
        for (int l = 0; l < 2; l++) begin
            lane_valid[l]  = 1'b0;
            lane_tag[l]    = '0;
            lane_opcode[l] = '0;
            lane_data1[l]  = '0;
            lane_data2[l]  = '0;
            lane_immd[l]   = '0;
        end
        load_table();
        repeat (4) tick();
        rst_n_i = 1'b1;

        repeat (10) tick();
        if (wb_recv != 0 || pulses[0] != 0 || pulses[1] != 0)
            report_failure("output pulses seen while idle after reset");
        finish_test("idle after reset");

        run_table(0, 7);
        finish_test("arithmetic");
        run_table(8, 28);
        finish_test("logic, shift, compare and move");

        for (int r = 0; r < 28; r += 2) issue_rows(r, r + 1);
        wait_drained();
        finish_test("both lanes at once");

        wb_hold = 1'b1;
        base = wb_recv;
        for (int r = 0; r < 6; r++) issue_own(r);
        repeat (20) tick();
        if (wb_recv - base > `WB_CREDITS)
            report_failure("more results than writeback credits while credits were withheld");
        wb_hold = 1'b0;
        wait_drained();
        finish_test("writeback back-pressure");

        // lane 0 fills up behind a stalled writeback.
        wb_hold = 1'b1;
        pulse_base = pulses[0];
        for (int r = 8; r < 8 + `LANE_DEPTH; r++) issue_rows(r, -1);
        repeat (20) tick();
        held = pulses[0];
        repeat (10) tick();
        if (pulses[0] != held || held - pulse_base >= `LANE_DEPTH)
            report_failure("issue credits kept coming while the result register was full");
        wb_hold = 1'b0;
        wait_drained();
        if (pulses[0] - pulse_base != `LANE_DEPTH)
            report_failure("issue credit pulses do not add up to the instructions issued");
        finish_test("issue credits");

        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 test_num, passed, failed, mon_errors + drv_errors);
        if (failed == 0 && mon_errors + drv_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+rtl
+incdir+verif
rtl/exec_pkg.sv
rtl/issue_if.sv
rtl/lane_result_if.sv
rtl/simple_alu.sv
rtl/alu_lane.sv
rtl/result_merge.sv
rtl/exec_cluster.sv
verif/exec_cluster_tb.sv
